// ==== Makefile ====
LOG = sim.log

.PHONY: all run lint clean

all: run

obj_dir/ctrlUnitTb: verilog.f source/*.sv tb/ctrlUnitTb.sv
	verilator --binary --assert --timescale 1ns/100ps --top-module ctrlUnitTb \
		-f verilog.f -o ctrlUnitTb

run: obj_dir/ctrlUnitTb
	./obj_dir/ctrlUnitTb > $(LOG) 2>&1 || echo "Result: FAILED" >> $(LOG)
	@cat $(LOG)
	@! grep -q "Result: FAILED" $(LOG)

lint:
	verilator --lint-only -Wall --timescale 1ns/100ps --top-module ctrlUnit \
		source/ctrlPkg.sv source/instrDecoder.sv source/stateSequencer.sv \
		source/controlWordGen.sv source/ctrlUnit.sv

clean:
	rm -rf obj_dir $(LOG)

// ==== source/controlWordGen.sv ====
module controlWordGen import ctrlPkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  state_t       state,
    input  aluOp_t       aluOp,
    input  shiftOp_t     shiftOp,
    input  opcode_t      opcode,
    input  branchFlags_t flags,
    output ctrlWord_t    ctrl
);

    ctrlWord_t word;
    ctrlWord_t stackInitWord;
    logic      takeBranch;

    // Loads the stack pointer while the processor sits in reset
    always_comb begin
        stackInitWord = idleWord;
        stackInitWord.regWrite = 1'b1;
        stackInitWord.regDest = destStackPtr;
        stackInitWord.wbSrc = wbStackInit;
    end

    always_comb begin
        case (opcode)
            opBeq:   takeBranch = flags.eq;
            opBne:   takeBranch = !flags.eq;
            opBgt:   takeBranch = flags.gt;
            opBle:   takeBranch = !flags.gt;
            default: takeBranch = 1'b0;
        endcase
    end

    always_comb begin
        word = idleWord;

        case (state)
            // PC + 4 on the ALU
            stFetch1: begin
                word.aluSrcB = 2'b01;
                word.aluOp = aluAdd;
            end
            stFetch2: begin
                word.irWrite = 1'b1;
                word.pcWrite = 1'b1;
                word.aluSrcB = 2'b01;
                word.aluOp = aluAdd;
                word.pcSrc = pcAluResult;
            end
            // Branch target into ALUOut
            stDecode1: begin
                word.abWrite = 1'b1;
                word.aluOutWrite = 1'b1;
                word.aluSrcB = 2'b10;
                word.aluOp = aluAdd;
            end
            stAluExec: begin
                word.aluSrcA = 1'b1;
                word.aluOp = aluOp;
                word.aluOutWrite = 1'b1;
            end
            // ALU inputs held stable during write-back
            stAluWrite: begin
                word.aluSrcA = 1'b1;
                word.aluOp = aluOp;
                word.regWrite = 1'b1;
                word.regDest = destRd;
                word.wbSrc = wbAluOut;
            end
            stShiftLoadImm: begin
                word.shiftOp = shLoad;
                word.shiftAmtSel = 2'b01;
                word.shiftSrcSel = 1'b1;
            end
            stShiftLoadVar: begin
                word.shiftOp = shLoad;
                word.shiftAmtSel = 2'b00;
                word.shiftSrcSel = 1'b0;
            end
            stShiftRun: begin
                word.shiftOp = shiftOp;
            end
            stShiftWrite: begin
                word.regWrite = 1'b1;
                word.regDest = destRd;
                word.wbSrc = wbShiftReg;
            end
            stSetLess: begin
                word.aluSrcA = 1'b1;
                word.aluOp = aluOp;
                word.regWrite = 1'b1;
                word.regDest = destRd;
                word.wbSrc = wbLessThan;
            end
            stAddImmExec: begin
                word.aluSrcA = 1'b1;
                word.aluSrcB = 2'b11;
                word.aluOp = aluOp;
                word.aluOutWrite = 1'b1;
            end
            stAddImmWrite: begin
                word.aluSrcA = 1'b1;
                word.aluSrcB = 2'b11;
                word.aluOp = aluOp;
                word.regWrite = 1'b1;
                word.regDest = destRt;
                word.wbSrc = wbAluOut;
            end
            stBranchStart: begin
                word.aluSrcA = 1'b1;
                word.aluOp = aluOp;
                word.pcSrc = pcBranchTarget;
            end
            // Flags are settled by now
            stBranchEnd: begin
                word.aluSrcA = 1'b1;
                word.aluOp = aluOp;
                word.pcSrc = pcBranchTarget;
                word.pcWrite = takeBranch;
            end
            default: begin
                word = idleWord;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ctrl <= stackInitWord;
        end else begin
            ctrl <= word;
        end
    end

    fetchWritesPc: assert property (
        @(posedge clk) disable iff (rst)
        ctrl.irWrite |-> (ctrl.pcWrite && ctrl.pcSrc == pcAluResult)
    ) else $error("irWrite without PC increment");

endmodule

// ==== source/ctrlPkg.sv ====
package ctrlPkg;

    // Primary opcode field of the instruction
    typedef enum logic [5:0] {
        opRType = 6'b000000,
        opBeq   = 6'b000100,
        opBne   = 6'b000101,
        opBle   = 6'b000110,
        opBgt   = 6'b000111,
        opAddi  = 6'b001000,
        opAddiu = 6'b001001
    } opcode_t;

    // R-type function field
    typedef enum logic [5:0] {
        fnSll  = 6'b000000,
        fnSrl  = 6'b000010,
        fnSra  = 6'b000011,
        fnSllv = 6'b000100,
        fnSrav = 6'b000111,
        fnAdd  = 6'b100000,
        fnSub  = 6'b100010,
        fnAnd  = 6'b100100,
        fnSlt  = 6'b101010
    } funct_t;

    // Path taken after the second decode state
    typedef enum logic [3:0] {
        clsArith,
        clsShiftImm,
        clsShiftVar,
        clsSetLess,
        clsAddImm,
        clsBranch,
        clsUnknown
    } instrClass_t;

    typedef enum logic [4:0] {
        stFetch1,
        stFetch2,
        stDecode1,
        stDecode2,
        stAluExec,
        stAluWrite,
        stShiftLoadImm,
        stShiftLoadVar,
        stShiftRun,
        stShiftWrite,
        stSetLess,
        stAddImmExec,
        stAddImmWrite,
        stBranchStart,
        stBranchEnd,
        stClose
    } state_t;

    typedef enum logic [2:0] {
        aluLoad    = 3'b000,
        aluAdd     = 3'b001,
        aluSub     = 3'b010,
        aluAnd     = 3'b011,
        aluCompare = 3'b111
    } aluOp_t;

    typedef enum logic [2:0] {
        shHold         = 3'b000,
        shLoad         = 3'b001,
        shLeft         = 3'b010,
        shRightLogical = 3'b011,
        shRightArith   = 3'b100
    } shiftOp_t;

    typedef enum logic [1:0] {
        destRt       = 2'b00,
        destRd       = 2'b01,
        destStackPtr = 2'b10
    } regDest_t;

    // Register file write-back mux, datapath encoding
    typedef enum logic [3:0] {
        wbMemData   = 4'b0000,
        wbAluOut    = 4'b0101,
        wbShiftReg  = 4'b0110,
        wbLessThan  = 4'b0111,
        wbStackInit = 4'b1000
    } wbSrc_t;

    typedef enum logic [1:0] {
        pcAluOut       = 2'b00,
        pcAluResult    = 2'b10,
        pcBranchTarget = 2'b11
    } pcSrc_t;

    typedef struct packed {
        logic     pcWrite;
        logic     memWrite;
        logic     irWrite;
        logic     abWrite;
        logic     regWrite;
        logic     aluOutWrite;
        aluOp_t   aluOp;
        logic     aluSrcA;
        logic [1:0] aluSrcB;
        shiftOp_t shiftOp;
        logic [1:0] shiftAmtSel;
        logic     shiftSrcSel;
        regDest_t regDest;
        wbSrc_t   wbSrc;
        pcSrc_t   pcSrc;
        logic [1:0] addrSel;
    } ctrlWord_t;

    typedef struct packed {
        logic eq;
        logic gt;
    } branchFlags_t;

    // Every strobe low, every mux on its first input
    localparam ctrlWord_t idleWord = '{
        pcWrite:     1'b0,
        memWrite:    1'b0,
        irWrite:     1'b0,
        abWrite:     1'b0,
        regWrite:    1'b0,
        aluOutWrite: 1'b0,
        aluOp:       aluLoad,
        aluSrcA:     1'b0,
        aluSrcB:     2'b00,
        shiftOp:     shHold,
        shiftAmtSel: 2'b00,
        shiftSrcSel: 1'b0,
        regDest:     destRt,
        wbSrc:       wbMemData,
        pcSrc:       pcAluOut,
        addrSel:     2'b00
    };

endpackage

// ==== source/ctrlUnit.sv ====
module ctrlUnit import ctrlPkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  opcode_t      opcode,
    input  funct_t       funct,
    input  branchFlags_t flags,
    output ctrlWord_t    ctrl
);

    instrClass_t instrClass;
    aluOp_t      aluOp;
    shiftOp_t    shiftOp;
    state_t      state;

    instrDecoder decoder (
        .opcode     (opcode),
        .funct      (funct),
        .instrClass (instrClass),
        .aluOp      (aluOp),
        .shiftOp    (shiftOp)
    );

    stateSequencer sequencer (
        .clk        (clk),
        .rst        (rst),
        .instrClass (instrClass),
        .state      (state)
    );

    // Word of each state appears one clock later
    controlWordGen wordGen (
        .clk     (clk),
        .rst     (rst),
        .state   (state),
        .aluOp   (aluOp),
        .shiftOp (shiftOp),
        .opcode  (opcode),
        .flags   (flags),
        .ctrl    (ctrl)
    );

endmodule

// ==== source/instrDecoder.sv ====
module instrDecoder import ctrlPkg::*; (
    input  opcode_t     opcode,
    input  funct_t      funct,
    output instrClass_t instrClass,
    output aluOp_t      aluOp,
    output shiftOp_t    shiftOp
);

    always_comb begin
        instrClass = clsUnknown;
        aluOp = aluLoad;
        shiftOp = shHold;

        case (opcode)
            opRType: begin
                case (funct)
                    fnAdd: begin
                        instrClass = clsArith;
                        aluOp = aluAdd;
                    end
                    fnSub: begin
                        instrClass = clsArith;
                        aluOp = aluSub;
                    end
                    fnAnd: begin
                        instrClass = clsArith;
                        aluOp = aluAnd;
                    end
                    fnSlt: begin
                        instrClass = clsSetLess;
                        aluOp = aluCompare;
                    end
                    // Amount from the shamt field
                    fnSll: begin
                        instrClass = clsShiftImm;
                        shiftOp = shLeft;
                    end
                    fnSrl: begin
                        instrClass = clsShiftImm;
                        shiftOp = shRightLogical;
                    end
                    fnSra: begin
                        instrClass = clsShiftImm;
                        shiftOp = shRightArith;
                    end
                    // Amount from a register
                    fnSllv: begin
                        instrClass = clsShiftVar;
                        shiftOp = shLeft;
                    end
                    fnSrav: begin
                        instrClass = clsShiftVar;
                        shiftOp = shRightArith;
                    end
                    default: begin
                        instrClass = clsUnknown;
                    end
                endcase
            end
            opAddi, opAddiu: begin
                instrClass = clsAddImm;
                aluOp = aluAdd;
            end
            opBeq, opBne, opBgt, opBle: begin
                instrClass = clsBranch;
                aluOp = aluCompare;
            end
            default: begin
                instrClass = clsUnknown;
            end
        endcase
    end

endmodule

// ==== source/stateSequencer.sv ====
module stateSequencer import ctrlPkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  instrClass_t instrClass,
    output state_t      state
);

    state_t nextState;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= stFetch1;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = stFetch1;

        case (state)
            stFetch1: begin
                nextState = stFetch2;
            end
            stFetch2: begin
                nextState = stDecode1;
            end
            stDecode1: begin
                nextState = stDecode2;
            end
            // Only branch point of the sequence
            stDecode2: begin
                case (instrClass)
                    clsArith:    nextState = stAluExec;
                    clsSetLess:  nextState = stSetLess;
                    clsShiftImm: nextState = stShiftLoadImm;
                    clsShiftVar: nextState = stShiftLoadVar;
                    clsAddImm:   nextState = stAddImmExec;
                    clsBranch:   nextState = stBranchStart;
                    default:     nextState = stClose;
                endcase
            end
            stAluExec: begin
                nextState = stAluWrite;
            end
            stAluWrite: begin
                nextState = stClose;
            end
            stShiftLoadImm, stShiftLoadVar: begin
                nextState = stShiftRun;
            end
            stShiftRun: begin
                nextState = stShiftWrite;
            end
            stShiftWrite: begin
                nextState = stClose;
            end
            stSetLess: begin
                nextState = stClose;
            end
            stAddImmExec: begin
                nextState = stAddImmWrite;
            end
            stAddImmWrite: begin
                nextState = stClose;
            end
            stBranchStart: begin
                nextState = stBranchEnd;
            end
            stBranchEnd: begin
                nextState = stClose;
            end
            stClose: begin
                nextState = stFetch1;
            end
            default: begin
                nextState = stFetch1;
            end
        endcase
    end

    closeToFetch: assert property (
        @(posedge clk) disable iff (rst)
        state == stClose |=> state == stFetch1
    ) else $error("close state not followed by fetch1");

    // Unrecognised instructions skip straight to the end
    unknownToClose: assert property (
        @(posedge clk) disable iff (rst)
        (state == stDecode2 && instrClass == clsUnknown) |=> state == stClose
    ) else $error("unknown instruction did not go to close");

endmodule

// ==== tb/ctrlCases.txt ====
# opcode funct eq gt length aluOp shiftOp wbSrc regDest regWrites pcWrites (all hex)
# aluOp wbSrc regDest are taken at the regWrite pulse, shiftOp is the shift command issued
00 20 0 0 7 1 0 5 1 1 1
00 22 0 0 7 2 0 5 1 1 1
00 24 0 0 7 3 0 5 1 1 1
00 2a 0 0 6 7 0 7 1 1 1
00 00 0 0 8 0 2 6 1 1 1
00 02 0 0 8 0 3 6 1 1 1
00 03 0 0 8 0 4 6 1 1 1
00 04 0 0 8 0 2 6 1 1 1
00 07 0 0 8 0 4 6 1 1 1
08 00 0 0 7 1 0 5 0 1 1
09 3f 0 0 7 1 0 5 0 1 1
04 00 1 0 7 0 0 0 0 0 2
04 00 0 0 7 0 0 0 0 0 1
04 20 1 1 7 0 0 0 0 0 2
05 00 0 0 7 0 0 0 0 0 2
05 00 1 0 7 0 0 0 0 0 1
07 00 0 1 7 0 0 0 0 0 2
07 00 1 0 7 0 0 0 0 0 1
06 00 0 0 7 0 0 0 0 0 2
06 00 0 1 7 0 0 0 0 0 1
23 00 0 0 5 0 0 0 0 0 1
00 20 0 0 7 1 0 5 1 1 1
00 25 0 0 5 0 0 0 0 0 1
00 2a 0 0 6 7 0 7 1 1 1
2b 11 1 1 5 0 0 0 0 0 1
00 00 0 0 8 0 2 6 1 1 1
09 00 0 0 7 1 0 5 0 1 1
00 22 0 0 7 2 0 5 1 1 1

// ==== tb/ctrlUnitTb.sv ====
module ctrlUnitTb import ctrlPkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    typedef struct packed {
        opcode_t      opcode;
        funct_t       funct;
        branchFlags_t flags;
        int           length;
        aluOp_t       aluOp;
        shiftOp_t     shiftOp;
        wbSrc_t       wbSrc;
        regDest_t     regDest;
        int           regWrites;
        int           pcWrites;
    } caseEntry_t;

    logic         clk = 1'b0;
    logic         rst;
    opcode_t      opcode;
    funct_t       funct;
    branchFlags_t flags;
    ctrlWord_t    ctrl;

    caseEntry_t cases[$];
    bit         casesLoaded;
    int         caseErrors;
    int         passCount;
    int         failCount;

    ctrlUnit uut (
        .clk    (clk),
        .rst    (rst),
        .opcode (opcode),
        .funct  (funct),
        .flags  (flags),
        .ctrl   (ctrl)
    );

    always #2 clk = ~clk;

    task automatic reportMismatch(input string what);
        $display("mismatch at %0.1f ns: %s", $realtime, what);
        caseErrors++;
    endtask

    task automatic checkAluOp(input string tag, input aluOp_t got, input aluOp_t exp);
        if (got !== exp) begin
            reportMismatch($sformatf("%s aluOp expected %s got %s (%0h)",
                tag, exp.name(), got.name(), got));
        end
    endtask

    task automatic checkShiftOp(input string tag, input shiftOp_t got, input shiftOp_t exp);
        if (got !== exp) begin
            reportMismatch($sformatf("%s shiftOp expected %s got %s (%0h)",
                tag, exp.name(), got.name(), got));
        end
    endtask

    task automatic checkWbSrc(input string tag, input wbSrc_t got, input wbSrc_t exp);
        if (got !== exp) begin
            reportMismatch($sformatf("%s wbSrc expected %s got %s (%0h)",
                tag, exp.name(), got.name(), got));
        end
    endtask

    task automatic checkRegDest(input string tag, input regDest_t got, input regDest_t exp);
        if (got !== exp) begin
            reportMismatch($sformatf("%s regDest expected %s got %s (%0h)",
                tag, exp.name(), got.name(), got));
        end
    endtask

    task automatic checkCount(input string tag, input string what, input int got, input int exp);
        if (got != exp) begin
            reportMismatch($sformatf("%s %s expected %0d got %0d", tag, what, exp, got));
        end
    endtask

    task automatic checkStrobe(input string tag, input string what, input logic got,
                               input logic exp);
        if (got !== exp) begin
            reportMismatch($sformatf("%s %s expected %b got %b", tag, what, exp, got));
        end
    endtask

    task automatic finishTest(input string tag);
        if (caseErrors == 0) begin
            passCount++;
            $display("%s: ok", tag);
        end else begin
            failCount++;
            $display("%s: %0d error(s)", tag, caseErrors);
        end
    endtask

    // Lines that do not hold all eleven columns are skipped
    task automatic loadCases();
        int         fd;
        int         fields;
        int         v [0:10];
        string      line;
        caseEntry_t entry;
        fd = $fopen("tb/ctrlCases.txt", "r");
        if (fd == 0) begin
            $display("error: could not open the case file tb/ctrlCases.txt");
            failCount++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h", v[0], v[1], v[2],
                    v[3], v[4], v[5], v[6], v[7], v[8], v[9], v[10]);
                if (fields == 11) begin
                    entry.opcode = opcode_t'(v[0][5:0]);
                    entry.funct = funct_t'(v[1][5:0]);
                    entry.flags.eq = v[2][0];
                    entry.flags.gt = v[3][0];
                    entry.length = v[4];
                    entry.aluOp = aluOp_t'(v[5][2:0]);
                    entry.shiftOp = shiftOp_t'(v[6][2:0]);
                    entry.wbSrc = wbSrc_t'(v[7][3:0]);
                    entry.regDest = regDest_t'(v[8][1:0]);
                    entry.regWrites = v[9];
                    entry.pcWrites = v[10];
                    cases.push_back(entry);
                end
            end
            $fclose(fd);
            if (cases.size() == 0) begin
                $display("error: the case file holds no cases");
                failCount++;
            end
        end
    endtask

    task automatic checkResetSequence();
        string tag;
        int    cycles;
        tag = "reset";
        caseErrors = 0;
        @(negedge clk);
        checkStrobe(tag, "regWrite", ctrl.regWrite, 1'b1);
        checkRegDest(tag, ctrl.regDest, destStackPtr);
        checkWbSrc(tag, ctrl.wbSrc, wbStackInit);
        checkStrobe(tag, "pcWrite", ctrl.pcWrite, 1'b0);
        checkStrobe(tag, "irWrite", ctrl.irWrite, 1'b0);
        checkStrobe(tag, "memWrite", ctrl.memWrite, 1'b0);
        cycles = 1;
        while (!ctrl.irWrite && cycles < 8) begin
            @(negedge clk);
            cycles++;
            if (cycles == 2) begin
                checkStrobe(tag, "regWrite after reset", ctrl.regWrite, 1'b0);
            end
        end
        checkCount(tag, "cycles to first irWrite", cycles, 3);
        checkStrobe(tag, "pcWrite with irWrite", ctrl.pcWrite, 1'b1);
        finishTest(tag);
    endtask

    // Entered with the irWrite word of this instruction on ctrl
    task automatic runCase(input int idx);
        caseEntry_t c;
        string      tag;
        int         length;
        int         regWrites;
        int         pcWrites;
        aluOp_t     seenAlu;
        shiftOp_t   seenShift;
        wbSrc_t     seenWb;
        regDest_t   seenDest;
        c = cases[idx];
        tag = $sformatf("case %0d (op %h fn %h eq %b gt %b)", idx, c.opcode, c.funct,
            c.flags.eq, c.flags.gt);
        caseErrors = 0;
        length = 1;
        regWrites = ctrl.regWrite ? 1 : 0;
        pcWrites = ctrl.pcWrite ? 1 : 0;
        seenAlu = aluLoad;
        seenShift = shHold;
        seenWb = wbMemData;
        seenDest = destRt;
        // IR loads on the edge that ends the fetch word
        @(posedge clk);
        #0.5;
        opcode = c.opcode;
        funct = c.funct;
        flags = c.flags;
        @(negedge clk);
        while (!ctrl.irWrite) begin
            length++;
            if (ctrl.regWrite) begin
                regWrites++;
                seenAlu = ctrl.aluOp;
                seenWb = ctrl.wbSrc;
                seenDest = ctrl.regDest;
            end
            if (ctrl.pcWrite) begin
                pcWrites++;
            end
            if (ctrl.shiftOp inside {shLeft, shRightLogical, shRightArith}) begin
                seenShift = ctrl.shiftOp;
            end
            @(negedge clk);
        end
        checkCount(tag, "length", length, c.length);
        checkCount(tag, "regWrite pulses", regWrites, c.regWrites);
        checkCount(tag, "pcWrite pulses", pcWrites, c.pcWrites);
        checkAluOp(tag, seenAlu, c.aluOp);
        checkShiftOp(tag, seenShift, c.shiftOp);
        checkWbSrc(tag, seenWb, c.wbSrc);
        checkRegDest(tag, seenDest, c.regDest);
        finishTest(tag);
    endtask

    initial begin
        rst = 1'b1;
        opcode = opRType;
        funct = fnAdd;
        flags = '0;
        passCount = 0;
        failCount = 0;
        caseErrors = 0;
        loadCases();
        casesLoaded = 1'b1;
        repeat (3) @(posedge clk);
        #0.5;
        rst = 1'b0;
        checkResetSequence();
        foreach (cases[i]) begin
            runCase(i);
        end
        $display("tests passed %0d, failed %0d", passCount, failCount);
        if (failCount == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // No instruction is longer than 8 cycles
    initial begin
        realtime limit;
        wait (casesLoaded);
        limit = cases.size() * 8 * 4.0 + 200.0;
        #(limit);
        $display("timeout: the control unit stopped fetching instructions");
        $display("Result: FAILED");
        $finish;
    end

endmodule

// ==== verilog.f ====
source/ctrlPkg.sv
source/instrDecoder.sv
source/stateSequencer.sv
source/controlWordGen.sv
source/ctrlUnit.sv
tb/ctrlUnitTb.sv
